// File: action_ram.sv
`timescale 1ns/1ns
`include "deparser_params.svh"

module action_ram (
	input  logic                 clk,
	input  logic                 wr_en,
	input  logic [`RAM_AW-1:0]   wr_addr,
	input  logic [`ENTRY_W-1:0]  wr_data,
	input  logic [`RAM_AW-1:0]   rd_addr,
	output logic [`ENTRY_W-1:0]  rd_data
);

	logic [`ENTRY_W-1:0] mem [0:(1<<`RAM_AW)-1];

	// all entries start invalid
	initial begin
		for (int i = 0; i < (1<<`RAM_AW); i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];  // registered read
	end

endmodule

// File: buf_if.sv
`timescale 1ns/1ns
`include "deparser_params.svh"

interface buf_if;
	logic                           load_en;
	logic [$clog2(`BUF_BEATS)-1:0]  load_sel;
	logic                           meta_load;   // beat 0 tuser takes phv metadata
	logic                           patch_en;
	logic [2:0]                     out_sel;     // bit 2 set: fifo head, else stored beat
	logic                           beat_last;

	modport ctrl (
		output load_en, load_sel, meta_load, patch_en, out_sel,
		input  beat_last
	);

	modport store (
		input  load_en, load_sel, meta_load, patch_en, out_sel,
		output beat_last
	);
endinterface

// File: cfg_writer.sv
`timescale 1ns/1ns
`include "deparser_params.svh"

module cfg_writer import deparser_pkg::*; (
	input  logic                 clk,
	input  logic                 aresetn,
	input  logic [`DATA_W-1:0]   ctrl_tdata,
	input  logic                 ctrl_tvalid,
	input  logic                 ctrl_tlast,
	output logic                 wr_en,
	output logic [`RAM_AW-1:0]   wr_addr,
	output logic [`ENTRY_W-1:0]  wr_data
);

	cfg_state_e state;
	logic       id_match;

	assign id_match = (ctrl_tdata[7:0] == 8'(`DEPARSER_MOD_ID));

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= HDR;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (ctrl_tvalid) begin
				case (state)
					HDR: begin
						if (!ctrl_tlast)
							state <= id_match ? ENTRY : SKIP;
					end
					ENTRY: begin
						wr_en <= 1'b1;
						state <= ctrl_tlast ? HDR : SKIP;  // trailing beats ignored
					end
					SKIP: begin
						if (ctrl_tlast)
							state <= HDR;
					end
					default: state <= HDR;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_tvalid && state == HDR)
			wr_addr <= ctrl_tdata[8 +: `RAM_AW];
		if (ctrl_tvalid && state == ENTRY)
			wr_data <= ctrl_tdata[`ENTRY_W-1:0];
	end

	// one entry per config packet
	a_single_write: assert property (@(posedge clk) disable iff (!aresetn)
		wr_en |=> !wr_en);

endmodule

// File: deparser_ctrl.sv
`timescale 1ns/1ns
`include "deparser_params.svh"

module deparser_ctrl import deparser_pkg::*; (
	input  logic  clk,
	input  logic  aresetn,
	input  logic  pkt_tlast,
	input  logic  pkt_empty,
	input  logic  phv_empty,
	input  logic  discard,
	output logic  pkt_rd,
	output logic  phv_rd,
	output logic  start,
	output logic  out_tvalid,
	input  logic  out_tready,
	buf_if.ctrl   bus
);

	depar_state_e state;
	depar_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		pkt_rd = 1'b0;
		phv_rd = 1'b0;
		start = 1'b0;
		out_tvalid = 1'b0;
		bus.load_en = 1'b0;
		bus.load_sel = '0;
		bus.meta_load = 1'b0;
		bus.patch_en = 1'b0;
		bus.out_sel = 3'd0;

		case (state)
			WAIT_PHV: begin
				if (!pkt_empty && !phv_empty) begin
					pkt_rd = 1'b1;
					if (discard) begin
						phv_rd = 1'b1;
						state_nxt = pkt_tlast ? WAIT_PHV : DROP;  // single beat drop
					end else begin
						bus.load_en = 1'b1;
						bus.meta_load = 1'b1;
						state_nxt = pkt_tlast ? EXTRACT : LOAD_1;
					end
				end
			end
			LOAD_1, LOAD_2, LOAD_3: begin
				if (!pkt_empty) begin
					pkt_rd = 1'b1;
					bus.load_en = 1'b1;
					bus.load_sel = state[1:0];
					if (pkt_tlast || state == LOAD_3)
						state_nxt = EXTRACT;
					else
						state_nxt = depar_state_e'(state + 4'd1);
				end
			end
			EXTRACT: begin
				start = 1'b1;  // ram output settled since WAIT_PHV
				state_nxt = PATCH;
			end
			PATCH: begin
				bus.patch_en = 1'b1;
				state_nxt = FLUSH_0;
			end
			FLUSH_0, FLUSH_1, FLUSH_2, FLUSH_3: begin
				bus.out_sel = 3'(state - FLUSH_0);
				out_tvalid = 1'b1;
				if (out_tready) begin
					phv_rd = (state == FLUSH_0);
					if (bus.beat_last)
						state_nxt = WAIT_PHV;
					else if (state == FLUSH_3)
						state_nxt = PASS;
					else
						state_nxt = depar_state_e'(state + 4'd1);
				end
			end
			PASS: begin
				bus.out_sel = 3'b100;
				out_tvalid = !pkt_empty;
				if (!pkt_empty && out_tready) begin
					pkt_rd = 1'b1;
					if (pkt_tlast)
						state_nxt = WAIT_PHV;
				end
			end
			DROP: begin
				if (!pkt_empty) begin
					pkt_rd = 1'b1;
					if (pkt_tlast)
						state_nxt = WAIT_PHV;
				end
			end
			default: state_nxt = WAIT_PHV;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			state <= WAIT_PHV;
		else
			state <= state_nxt;
	end

	// stalled beat stays on the bus from the same source
	a_hold: assert property (@(posedge clk) disable iff (!aresetn)
		out_tvalid && !out_tready |=> out_tvalid && $stable(bus.out_sel));

endmodule

// File: deparser_params.svh
`ifndef DEPARSER_PARAMS_SVH
`define DEPARSER_PARAMS_SVH

`define DATA_W          64
`define KEEP_W          (`DATA_W/8)
`define USER_W          128

`define BUF_BEATS       4
`define BUF_BYTES       (`BUF_BEATS*`KEEP_W)

`define NUM_ACT         4
`define NUM_CONT        4

// phv layout, low to high: 48b, 32b, 16b containers, then metadata
`define META_W          128
`define PHV_W           512
`define C48_OFF         0
`define C32_OFF         (`C48_OFF + 48*`NUM_CONT)
`define C16_OFF         (`C32_OFF + 32*`NUM_CONT)
`define META_OFF        (`C16_OFF + 16*`NUM_CONT)

`define RAM_AW          5
`define ACT_W           16
`define ENTRY_W         (`NUM_ACT*`ACT_W)

`define DISCARD_BIT     0
`define TBL_IDX_LSB     1
`define DEPARSER_MOD_ID 5

`endif

// File: deparser_pkg.sv
package deparser_pkg;

	// container kind, also gives the field length
	typedef enum logic [1:0] {
		CONT_NONE = 2'd0,
		CONT_C16  = 2'd1,
		CONT_C32  = 2'd2,
		CONT_C48  = 2'd3
	} cont_kind_e;

	// one slot of an action entry
	typedef struct packed {
		logic [4:0] offset;  // byte offset into the buffer
		logic [1:0] idx;     // container index
		cont_kind_e kind;
		logic [5:0] rsvd;
		logic       valid;
	} parse_act_t;

	typedef struct packed {
		logic [47:0] value;  // byte 0 lands at offset
		cont_kind_e  kind;
		logic [4:0]  offset;
	} field_t;

	typedef enum logic [3:0] {
		WAIT_PHV, LOAD_1, LOAD_2, LOAD_3,
		EXTRACT, PATCH,
		FLUSH_0, FLUSH_1, FLUSH_2, FLUSH_3,
		PASS, DROP
	} depar_state_e;

	typedef enum logic [2:0] {
		HDR, ENTRY, SKIP
	} cfg_state_e;

endpackage

// File: deparser_top.sv
`timescale 1ns/1ns
`include "deparser_params.svh"

module deparser_top import deparser_pkg::*; (
	input  logic                 clk,
	input  logic                 aresetn,

	input  logic [`DATA_W-1:0]   pkt_tdata,
	input  logic [`KEEP_W-1:0]   pkt_tkeep,
	input  logic [`USER_W-1:0]   pkt_tuser,
	input  logic                 pkt_tlast,
	input  logic                 pkt_empty,
	output logic                 pkt_rd,

	input  logic [`PHV_W-1:0]    phv_data,
	input  logic                 phv_empty,
	output logic                 phv_rd,

	output logic [`DATA_W-1:0]   out_tdata,
	output logic [`KEEP_W-1:0]   out_tkeep,
	output logic [`USER_W-1:0]   out_tuser,
	output logic                 out_tvalid,
	output logic                 out_tlast,
	input  logic                 out_tready,

	input  logic [`DATA_W-1:0]   ctrl_tdata,
	input  logic                 ctrl_tvalid,
	input  logic                 ctrl_tlast
);

	buf_if bus ();

	logic [`META_W-1:0]   meta;
	logic [`ENTRY_W-1:0]  entry;
	logic                 start;
	field_t               fields [`NUM_ACT];
	logic                 ram_wr_en;
	logic [`RAM_AW-1:0]   ram_wr_addr;
	logic [`ENTRY_W-1:0]  ram_wr_data;

	assign meta = phv_data[`META_OFF +: `META_W];

	deparser_ctrl u_ctrl (
		.clk        (clk),
		.aresetn    (aresetn),
		.pkt_tlast  (pkt_tlast),
		.pkt_empty  (pkt_empty),
		.phv_empty  (phv_empty),
		.discard    (meta[`DISCARD_BIT]),
		.pkt_rd     (pkt_rd),
		.phv_rd     (phv_rd),
		.start      (start),
		.out_tvalid (out_tvalid),
		.out_tready (out_tready),
		.bus        (bus.ctrl)
	);

	pkt_buffer u_buf (
		.clk       (clk),
		.aresetn   (aresetn),
		.pkt_tdata (pkt_tdata),
		.pkt_tkeep (pkt_tkeep),
		.pkt_tuser (pkt_tuser),
		.pkt_tlast (pkt_tlast),
		.meta      (meta),
		.fields    (fields),
		.bus       (bus.store),
		.out_tdata (out_tdata),
		.out_tkeep (out_tkeep),
		.out_tuser (out_tuser),
		.out_tlast (out_tlast)
	);

	action_ram u_ram (
		.clk     (clk),
		.wr_en   (ram_wr_en),
		.wr_addr (ram_wr_addr),
		.wr_data (ram_wr_data),
		.rd_addr (meta[`TBL_IDX_LSB +: `RAM_AW]),  // table index from phv head
		.rd_data (entry)
	);

	cfg_writer u_cfg (
		.clk         (clk),
		.aresetn     (aresetn),
		.ctrl_tdata  (ctrl_tdata),
		.ctrl_tvalid (ctrl_tvalid),
		.ctrl_tlast  (ctrl_tlast),
		.wr_en       (ram_wr_en),
		.wr_addr     (ram_wr_addr),
		.wr_data     (ram_wr_data)
	);

	for (genvar k = 0; k < `NUM_ACT; k++) begin : g_field
		field_extract u_field (
			.clk     (clk),
			.aresetn (aresetn),
			.start   (start),
			.act     (parse_act_t'(entry[`ACT_W*k +: `ACT_W])),
			.phv     (phv_data),
			.field   (fields[k])
		);
	end

endmodule

// File: field_extract.sv
`timescale 1ns/1ns
`include "deparser_params.svh"

module field_extract import deparser_pkg::*; (
	input  logic               clk,
	input  logic               aresetn,
	input  logic               start,
	input  parse_act_t         act,
	input  logic [`PHV_W-1:0]  phv,
	output field_t             field
);

	logic [47:0] c48;
	logic [31:0] c32;
	logic [15:0] c16;
	logic [47:0] value;
	cont_kind_e  kind;
	logic [47:0] value_q;
	cont_kind_e  kind_q;
	logic [4:0]  offset_q;

	assign c48 = phv[`C48_OFF + 48*act.idx +: 48];
	assign c32 = phv[`C32_OFF + 32*act.idx +: 32];
	assign c16 = phv[`C16_OFF + 16*act.idx +: 16];

	// msb of the container ends up in value byte 0
	always_comb begin
		value = '0;
		kind = CONT_NONE;
		if (act.valid) begin
			kind = act.kind;
			case (act.kind)
				CONT_C16:
					for (int j = 0; j < 2; j++)
						value[8*j +: 8] = c16[8*(1-j) +: 8];
				CONT_C32:
					for (int j = 0; j < 4; j++)
						value[8*j +: 8] = c32[8*(3-j) +: 8];
				CONT_C48:
					for (int j = 0; j < 6; j++)
						value[8*j +: 8] = c48[8*(5-j) +: 8];
				default: kind = CONT_NONE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			kind_q <= CONT_NONE;
		else if (start)
			kind_q <= kind;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			value_q <= value;
			offset_q <= act.offset;
		end
	end

	assign field = '{value: value_q, kind: kind_q, offset: offset_q};

endmodule

// File: pkt_buffer.sv
`timescale 1ns/1ns
`include "deparser_params.svh"

module pkt_buffer import deparser_pkg::*; (
	input  logic                 clk,
	input  logic                 aresetn,
	input  logic [`DATA_W-1:0]   pkt_tdata,
	input  logic [`KEEP_W-1:0]   pkt_tkeep,
	input  logic [`USER_W-1:0]   pkt_tuser,
	input  logic                 pkt_tlast,
	input  logic [`META_W-1:0]   meta,
	input  field_t               fields [`NUM_ACT],
	buf_if.store                 bus,
	output logic [`DATA_W-1:0]   out_tdata,
	output logic [`KEEP_W-1:0]   out_tkeep,
	output logic [`USER_W-1:0]   out_tuser,
	output logic                 out_tlast
);

	logic [`BUF_BYTES*8-1:0]  data_q;  // byte n at bits 8n+7:8n
	logic [`BUF_BYTES*8-1:0]  patched;
	logic [`KEEP_W-1:0]       keep_q [`BUF_BEATS];
	logic [`USER_W-1:0]       user_q [`BUF_BEATS];
	logic [`BUF_BEATS-1:0]    last_q;

	function automatic int unsigned field_len(cont_kind_e kind);
		case (kind)
			CONT_C16: return 2;
			CONT_C32: return 4;
			CONT_C48: return 6;
			default:  return 0;
		endcase
	endfunction

	// ascending slot order, higher slot wins on overlap
	always_comb begin
		patched = data_q;
		for (int s = 0; s < `NUM_ACT; s++) begin
			for (int j = 0; j < 6; j++) begin
				if (j < field_len(fields[s].kind) && fields[s].offset + j < `BUF_BYTES)
					patched[8*(fields[s].offset + j) +: 8] = fields[s].value[8*j +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.load_en) begin
			data_q[`DATA_W*bus.load_sel +: `DATA_W] <= pkt_tdata;
			keep_q[bus.load_sel] <= pkt_tkeep;
			user_q[bus.load_sel] <= bus.meta_load ? meta : pkt_tuser;
		end else if (bus.patch_en) begin
			data_q <= patched;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			last_q <= '0;
		else if (bus.load_en)
			last_q[bus.load_sel] <= pkt_tlast;
	end

	always_comb begin
		if (bus.out_sel[2]) begin  // pass mode
			out_tdata = pkt_tdata;
			out_tkeep = pkt_tkeep;
			out_tuser = pkt_tuser;
			out_tlast = pkt_tlast;
		end else begin
			out_tdata = data_q[`DATA_W*bus.out_sel[1:0] +: `DATA_W];
			out_tkeep = keep_q[bus.out_sel[1:0]];
			out_tuser = user_q[bus.out_sel[1:0]];
			out_tlast = last_q[bus.out_sel[1:0]];
		end
	end

	assign bus.beat_last = last_q[bus.out_sel[1:0]];

	// action entries must keep fields inside the stored beats
	for (genvar s = 0; s < `NUM_ACT; s++) begin : g_chk
		a_field_fits: assert property (@(posedge clk) disable iff (!aresetn)
			bus.patch_en |-> fields[s].offset + field_len(fields[s].kind) <= `BUF_BYTES);
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_deparser -o sim_deparser
./obj_dir/sim_deparser

// File: tb_deparser.sv
`timescale 1ns/1ns
`include "deparser_params.svh"

module tb_deparser import deparser_pkg::*; ();

	localparam int NROWS = 6;

	typedef struct packed {
		logic [`DATA_W-1:0] data;
		logic [`KEEP_W-1:0] keep;
		logic [`USER_W-1:0] user;
		logic               last;
	} beat_t;

	logic                clk;
	logic                aresetn;
	logic [`DATA_W-1:0]  pkt_tdata;
	logic [`KEEP_W-1:0]  pkt_tkeep;
	logic [`USER_W-1:0]  pkt_tuser;
	logic                pkt_tlast;
	logic                pkt_empty;
	logic                pkt_rd;
	logic [`PHV_W-1:0]   phv_data;
	logic                phv_empty;
	logic                phv_rd;
	logic [`DATA_W-1:0]  out_tdata;
	logic [`KEEP_W-1:0]  out_tkeep;
	logic [`USER_W-1:0]  out_tuser;
	logic                out_tvalid;
	logic                out_tlast;
	logic                out_tready;
	logic [`DATA_W-1:0]  ctrl_tdata;
	logic                ctrl_tvalid;
	logic                ctrl_tlast;

	// stimulus table, one row per packet
	bit                  cfg_on    [NROWS];
	logic [7:0]          cfg_id    [NROWS];
	logic [`RAM_AW-1:0]  cfg_addr  [NROWS];
	logic [`ENTRY_W-1:0] cfg_entry [NROWS];
	bit                  cfg_tail  [NROWS];  // extra trailing config beat
	logic [`RAM_AW-1:0]  tbl_idx   [NROWS];
	bit                  discard   [NROWS];
	int                  nbeats    [NROWS];

	logic [`ENTRY_W-1:0] shadow [1<<`RAM_AW];  // expected ram contents
	logic [47:0]         cur_c48 [`NUM_CONT];
	logic [31:0]         cur_c32 [`NUM_CONT];
	logic [15:0]         cur_c16 [`NUM_CONT];
	logic [7:0]          ref_bytes [`BUF_BYTES];

	beat_t               src_pkt [$];  // not yet arrived
	beat_t               pkt_q [$];    // inside the fifo
	logic [`PHV_W-1:0]   src_phv [$];
	logic [`PHV_W-1:0]   phv_q [$];
	beat_t               exp_q [$];
	beat_t               exp_beat;

	deparser_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			$display("ERR time %0t ns signal %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [15:0] mk_act(input int off, input int idx, input cont_kind_e kind);
		parse_act_t a;
		a = '0;
		a.offset = 5'(off);
		a.idx = 2'(idx);
		a.kind = kind;
		a.valid = 1'b1;
		return a;
	endfunction

	task automatic set_row(input int r, input bit on, input int id, input int addr,
			input logic [`ENTRY_W-1:0] entry, input bit tail, input int idx, input bit disc,
			input int n);
		cfg_on[r] = on;
		cfg_id[r] = 8'(id);
		cfg_addr[r] = 5'(addr);
		cfg_entry[r] = entry;
		cfg_tail[r] = tail;
		tbl_idx[r] = 5'(idx);
		discard[r] = disc;
		nbeats[r] = n;
	endtask

	task automatic load_table();
		logic [`ENTRY_W-1:0] e1;
		logic [`ENTRY_W-1:0] e2;
		logic [`ENTRY_W-1:0] e3;
		// c32 across beats 0/1, c48 across 1/2, slot 3 overlaps slot 2
		e1 = {mk_act(14, 3, CONT_C16), mk_act(12, 0, CONT_C48),
			mk_act(6, 2, CONT_C32), mk_act(2, 1, CONT_C16)};
		e2 = {48'h0, mk_act(0, 3, CONT_C48)};
		e3 = {mk_act(21, 0, CONT_C16), 16'h0, mk_act(20, 2, CONT_C48), mk_act(28, 1, CONT_C32)};
		set_row(0, 0, 0, 0, '0, 0, 0, 0, 3);
		set_row(1, 1, `DEPARSER_MOD_ID, 3, e1, 0, 3, 0, 4);
		set_row(2, 1, 7, 3, e2, 1, 3, 0, 5);  // foreign id
		set_row(3, 0, 0, 0, '0, 0, 3, 1, 2);
		set_row(4, 1, `DEPARSER_MOD_ID, 9, e3, 1, 9, 0, 7);
		set_row(5, 0, 0, 0, '0, 0, 3, 0, 1);
		for (int i = 0; i < (1<<`RAM_AW); i++)
			shadow[i] = '0;
	endtask

	task automatic send_cfg(input int r);
		logic [`DATA_W-1:0] beats [3];
		int nb;
		beats[0] = '0;
		beats[0][7:0] = cfg_id[r];
		beats[0][12:8] = cfg_addr[r];
		beats[1] = cfg_entry[r];
		beats[2] = {$urandom, $urandom};
		nb = cfg_tail[r] ? 3 : 2;
		for (int i = 0; i < nb; i++) begin
			@(negedge clk);
			ctrl_tvalid = 1'b1;
			ctrl_tdata = beats[i];
			ctrl_tlast = (i == nb - 1);
		end
		@(negedge clk);
		ctrl_tvalid = 1'b0;
		ctrl_tlast = 1'b0;
		if (cfg_id[r] == 8'(`DEPARSER_MOD_ID))
			shadow[cfg_addr[r]] = cfg_entry[r];
	endtask

	// patch rule on the byte image, msb of the container at the lowest offset
	task automatic patch_ref(input logic [`ENTRY_W-1:0] entry);
		parse_act_t a;
		int len;
		logic [47:0] cont;
		for (int k = 0; k < `NUM_ACT; k++) begin
			a = parse_act_t'(entry[`ACT_W*k +: `ACT_W]);
			len = 0;
			cont = '0;
			if (a.valid) begin
				case (a.kind)
					CONT_C16: begin len = 2; cont = 48'(cur_c16[a.idx]); end
					CONT_C32: begin len = 4; cont = 48'(cur_c32[a.idx]); end
					CONT_C48: begin len = 6; cont = cur_c48[a.idx]; end
					default:  len = 0;
				endcase
			end
			for (int j = 0; j < len; j++)
				ref_bytes[a.offset + j] = cont[8*(len-1-j) +: 8];
		end
	endtask

	task automatic run_row(input int r);
		beat_t beats [8];
		beat_t e;
		logic [`META_W-1:0] meta;
		logic [`PHV_W-1:0] phv;
		if (cfg_on[r])
			send_cfg(r);
		repeat (3) @(negedge clk);
		meta = {$urandom, $urandom, $urandom, $urandom};
		meta[`TBL_IDX_LSB +: `RAM_AW] = tbl_idx[r];
		meta[`DISCARD_BIT] = discard[r];
		phv = '0;
		for (int i = 0; i < `NUM_CONT; i++) begin
			cur_c48[i] = 48'({$urandom, $urandom});
			cur_c32[i] = $urandom;
			cur_c16[i] = 16'($urandom);
			phv[`C48_OFF + 48*i +: 48] = cur_c48[i];
			phv[`C32_OFF + 32*i +: 32] = cur_c32[i];
			phv[`C16_OFF + 16*i +: 16] = cur_c16[i];
		end
		phv[`META_OFF +: `META_W] = meta;
		for (int n = 0; n < `BUF_BYTES; n++)
			ref_bytes[n] = 8'h00;
		for (int b = 0; b < nbeats[r]; b++) begin
			beats[b].data = {$urandom, $urandom};
			beats[b].keep = (b == nbeats[r] - 1) ? 8'h3f : 8'hff;
			beats[b].user = {$urandom, $urandom, $urandom, $urandom};
			beats[b].last = (b == nbeats[r] - 1);
			for (int i = 0; i < 8 && b < `BUF_BEATS; i++)
				ref_bytes[8*b + i] = beats[b].data[8*i +: 8];
		end
		patch_ref(shadow[tbl_idx[r]]);
		@(posedge clk);
		src_phv.push_back(phv);
		for (int b = 0; b < nbeats[r]; b++) begin
			src_pkt.push_back(beats[b]);
			e = beats[b];
			if (b < `BUF_BEATS) begin
				for (int i = 0; i < 8; i++)
					e.data[8*i +: 8] = ref_bytes[8*b + i];
			end
			if (b == 0)
				e.user = meta;
			if (!discard[r])
				exp_q.push_back(e);
		end
		do
			@(negedge clk);
		while (exp_q.size() != 0 || src_pkt.size() + pkt_q.size() != 0 ||
			src_phv.size() + phv_q.size() != 0);
	endtask

	// fifo models and tready, arrivals come with random gaps
	initial begin
		pkt_tdata = '0;
		pkt_tkeep = '0;
		pkt_tuser = '0;
		pkt_tlast = 1'b0;
		pkt_empty = 1'b1;
		phv_data = '0;
		phv_empty = 1'b1;
		out_tready = 1'b0;
		forever begin
			@(negedge clk);
			if (src_pkt.size() > 0 && $urandom_range(3) != 0)
				pkt_q.push_back(src_pkt.pop_front());
			if (src_phv.size() > 0 && $urandom_range(3) != 0)
				phv_q.push_back(src_phv.pop_front());
			pkt_empty = (pkt_q.size() == 0);
			{pkt_tdata, pkt_tkeep, pkt_tuser, pkt_tlast} = pkt_empty ? '0 : pkt_q[0];
			phv_empty = (phv_q.size() == 0);
			phv_data = phv_empty ? '0 : phv_q[0];
			out_tready = ($urandom_range(3) != 0);
		end
	end

	always @(posedge clk) begin
		if (aresetn) begin
			if (pkt_rd) begin
				if (pkt_q.size() == 0) begin
					$display("packet FIFO was read while empty at %0t ns", $time);
					abort_run();
				end else
					void'(pkt_q.pop_front());
			end
			if (phv_rd) begin
				if (phv_q.size() == 0) begin
					$display("PHV FIFO was read while empty at %0t ns", $time);
					abort_run();
				end else
					void'(phv_q.pop_front());
			end
			if (out_tvalid && out_tready) begin
				if (exp_q.size() == 0) begin
					$display("output beat at %0t ns when none was expected", $time);
					abort_run();
				end else begin
					exp_beat = exp_q.pop_front();
					check("out_tdata", 128'(out_tdata), 128'(exp_beat.data));
					check("out_tkeep", 128'(out_tkeep), 128'(exp_beat.keep));
					check("out_tuser", out_tuser, exp_beat.user);
					check("out_tlast", 128'(out_tlast), 128'(exp_beat.last));
				end
			end
		end
	end

	initial begin
		int limit;
		limit = 0;
		@(posedge aresetn);
		for (int r = 0; r < NROWS; r++)
			limit += nbeats[r];
		repeat (limit * 50) @(posedge clk);
		$display("watchdog expired, table not done after %0d cycles", limit * 50);
		abort_run();
	end

	initial begin
		void'($urandom(41));
		aresetn = 1'b0;
		ctrl_tdata = '0;
		ctrl_tvalid = 1'b0;
		ctrl_tlast = 1'b0;
		load_table();
		repeat (3) @(negedge clk);
		aresetn = 1'b1;
		for (int r = 0; r < NROWS; r++)
			run_row(r);
		repeat (5) @(negedge clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
deparser_pkg.sv
buf_if.sv
action_ram.sv
cfg_writer.sv
field_extract.sv
pkt_buffer.sv
deparser_ctrl.sv
deparser_top.sv
tb_deparser.sv
